// File: rtl/dbg_pkg.sv
/*
 * Debug co-processor shared definitions.
 * Debug NoC flit format, bus command and read result records,
 * header field positions and the address map constants.
 */
package dbg_pkg;

   typedef enum logic [1:0] {
      PAYLOAD = 2'b00,
      HEADER  = 2'b01,
      LAST    = 2'b10,
      SINGLE  = 2'b11                      // Single-flit packet, not used for requests
   } flit_type_t;

   typedef logic [15:0] flit_data_t;
   typedef logic [4:0]  node_id_t;         // NoC node address
   typedef logic [31:0] bus_addr_t;
   typedef logic [31:0] bus_data_t;

   typedef struct packed {
      flit_type_t ftype;                   // Bits 17:16
      flit_data_t data;
   } flit_t;

   typedef enum logic [1:0] {
      OP_WRITE = 2'b01,
      OP_READ  = 2'b10,
      OP_RESP  = 2'b11                     // Response packets only
   } cmd_op_t;

   typedef struct packed {
      cmd_op_t   op;
      node_id_t  src;                      // Requester
      bus_addr_t addr;
      bus_data_t wdata;
   } bus_cmd_t;

   typedef enum logic [1:0] {
      ST_UNMAPPED = 2'b00,
      ST_EMPTY    = 2'b01,
      ST_OK       = 2'b11
   } rsp_status_t;

   typedef struct packed {
      node_id_t    node;                   // Where the response goes
      rsp_status_t status;
      bus_data_t   rdata;                  // Zero unless ST_OK
   } rd_result_t;

   // Header flit field positions
   localparam int HDR_DST_MSB = 15;
   localparam int HDR_DST_LSB = 11;
   localparam int HDR_OP_MSB  = 10;
   localparam int HDR_OP_LSB  = 9;
   localparam int HDR_STS_MSB = 8;        // Responses only
   localparam int HDR_STS_LSB = 7;
   localparam int HDR_SRC_MSB = 4;
   localparam int HDR_SRC_LSB = 0;

   localparam logic [11:0] QUEUE_MATCH = 12'hfe8;   // Against addr[31:20]

endpackage

// File: rtl/flit_decoder.sv
/*
 * Request flit decoder.
 * Collects the flits of a debug NoC request packet and presents
 * the finished read or write as one bus command. Stray flits and
 * headers with an unknown op are consumed and dropped.
 */
module flit_decoder import dbg_pkg::*; (
   input  logic     clk_i,
   input  logic     rst_n_i,
   input  flit_t    flit_i,
   input  logic     flit_valid_i,
   output logic     flit_ready_o,
   output bus_cmd_t cmd_o,
   output logic     cmd_valid_o,
   input  logic     cmd_ready_i
);

   typedef enum logic [2:0] {
      IDLE, ADDR_HI, ADDR_LO, DATA_HI, DATA_LO, PENDING
   } state_t;

   state_t     state_q, state_d;
   bus_cmd_t   cmd_q;                      // Command under assembly
   logic [1:0] hdr_op;
   logic       hdr_ok;
   logic       is_last;
   logic       flit_acc;

   assign hdr_op  = flit_i.data[HDR_OP_MSB:HDR_OP_LSB];
   assign hdr_ok  = (flit_i.ftype == HEADER) && (hdr_op == OP_WRITE || hdr_op == OP_READ);
   assign is_last = flit_i.ftype == LAST;

   // Stall only while a finished command waits on the executor
   assign flit_ready_o = !(state_q == PENDING && !cmd_ready_i);
   assign flit_acc     = flit_valid_i && flit_ready_o;

   assign cmd_o       = cmd_q;
   assign cmd_valid_o = state_q == PENDING;

   always_comb begin
      state_d = state_q;
      case (state_q)
         IDLE, PENDING: begin              // Next header may overlap the hand-off
            if (flit_acc) state_d = hdr_ok ? ADDR_HI : IDLE;
            else if (cmd_ready_i) state_d = IDLE;
         end
         ADDR_HI: if (flit_acc) state_d = is_last ? IDLE : ADDR_LO;   // Short packet, drop
         ADDR_LO: begin
            if (flit_acc) begin
               if (cmd_q.op == OP_READ) state_d = is_last ? PENDING : IDLE;
               else state_d = is_last ? IDLE : DATA_HI;
            end
         end
         DATA_HI: if (flit_acc) state_d = is_last ? IDLE : DATA_LO;
         DATA_LO: if (flit_acc) state_d = PENDING;
         default: state_d = IDLE;
      endcase
   end

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) state_q <= IDLE;
      else state_q <= state_d;
   end

   // Field capture, one flit at a time
   always_ff @(posedge clk_i) begin
      if (flit_acc) begin
         case (state_q)
            IDLE, PENDING: begin
               if (hdr_ok) begin
                  cmd_q.op  <= cmd_op_t'(hdr_op);
                  cmd_q.src <= flit_i.data[HDR_SRC_MSB:HDR_SRC_LSB];
               end
            end
            ADDR_HI: cmd_q.addr[31:16]  <= flit_i.data;
            ADDR_LO: cmd_q.addr[15:0]   <= flit_i.data;
            DATA_HI: cmd_q.wdata[31:16] <= flit_i.data;
            DATA_LO: cmd_q.wdata[15:0]  <= flit_i.data;
            default: ;
         endcase
      end
   end

endmodule

// File: rtl/dbg_sram.sv
/*
 * Debug SRAM.
 * Single-port word memory with a registered read port.
 * Read data holds its value until the next read.
 */
module dbg_sram import dbg_pkg::*; #(
   parameter int MEM_AW = 8
) (
   input  logic              clk_i,
   input  logic              we_i,
   input  logic              re_i,
   input  logic [MEM_AW-1:0] addr_i,
   input  bus_data_t         wdata_i,
   output bus_data_t         rdata_o
);

   bus_data_t mem [2**MEM_AW];             // Contents undefined after power-up

   always_ff @(posedge clk_i) begin
      if (we_i) mem[addr_i] <= wdata_i;
   end

   always_ff @(posedge clk_i) begin
      if (re_i) rdata_o <= mem[addr_i];    // Stays put between reads
   end

endmodule

// File: rtl/address_queue.sv
/*
 * Address queue.
 * Circular FIFO of 32-bit values. A push into a full queue and a
 * pop from an empty one are ignored. Pop data is registered.
 */
module address_queue import dbg_pkg::*; #(
   parameter int DEPTH = 8
) (
   input  logic      clk_i,
   input  logic      rst_n_i,
   input  logic      push_i,
   input  bus_data_t push_data_i,
   input  logic      pop_i,
   output bus_data_t pop_data_o,
   output logic      empty_o
);

   localparam int PW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int CW = $clog2(DEPTH + 1);

   bus_data_t     buf_q [DEPTH];
   logic [PW-1:0] wr_ptr_q, rd_ptr_q;
   logic [CW-1:0] count_q;
   logic          full;
   logic          do_push, do_pop;

   assign empty_o = count_q == '0;
   assign full    = count_q == CW'(DEPTH);
   assign do_push = push_i && !full;       // Dropped when full
   assign do_pop  = pop_i && !empty_o;

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         count_q  <= '0;
      end else begin
         if (do_push) wr_ptr_q <= (wr_ptr_q == PW'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
         if (do_pop) rd_ptr_q <= (rd_ptr_q == PW'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
         count_q <= count_q + CW'(do_push) - CW'(do_pop);
      end
   end

   always_ff @(posedge clk_i) begin
      if (do_push) buf_q[wr_ptr_q] <= push_data_i;
      if (do_pop) pop_data_o <= buf_q[rd_ptr_q];   // Oldest entry
   end

endmodule

// File: rtl/bus_executor.sv
/*
 * Bus command executor.
 * Decodes the command address to the SRAM, the address queue or
 * nothing, issues the access and holds the read result until the
 * response packer takes it.
 */
module bus_executor import dbg_pkg::*; #(
   parameter int MEM_AW      = 8,
   parameter int QUEUE_DEPTH = 8
) (
   input  logic       clk_i,
   input  logic       rst_n_i,
   input  bus_cmd_t   cmd_i,
   input  logic       cmd_valid_i,
   output logic       cmd_ready_o,
   output rd_result_t res_o,
   output logic       res_valid_o,
   input  logic       res_ready_i
);

   logic        in_sram, in_queue;
   logic        is_read, is_write;
   logic        rd_unmapped, imm_rd;
   logic        accept, rd_issue;
   logic        res_valid_q;
   node_id_t    res_node_q;
   rsp_status_t res_status_q;
   logic        sel_sram_q;                // Which slave holds rdata
   bus_data_t   sram_rdata, queue_rdata;
   logic        queue_empty;

   // Region decode
   assign in_sram  = !cmd_i.addr[31];
   assign in_queue = cmd_i.addr[31:20] == QUEUE_MATCH;
   assign is_read  = cmd_i.op == OP_READ;
   assign is_write = cmd_i.op == OP_WRITE;

   assign rd_unmapped = is_read && !in_sram && !in_queue;
   assign imm_rd      = cmd_valid_i && rd_unmapped && !res_valid_q;   // Answered this cycle

   // Unmapped read waits behind a held result
   assign cmd_ready_o = (!res_valid_o || res_ready_i) && !(res_valid_q && rd_unmapped);
   assign accept      = cmd_valid_i && cmd_ready_o;
   assign rd_issue    = accept && is_read && (in_sram || in_queue);

   dbg_sram #(
      .MEM_AW (MEM_AW)
   ) u_dbg_sram (
      .clk_i   (clk_i),
      .we_i    (accept && is_write && in_sram),
      .re_i    (rd_issue && in_sram),
      .addr_i  (cmd_i.addr[MEM_AW+1:2]),  // Word index
      .wdata_i (cmd_i.wdata),
      .rdata_o (sram_rdata)
   );

   address_queue #(
      .DEPTH (QUEUE_DEPTH)
   ) u_address_queue (
      .clk_i       (clk_i),
      .rst_n_i     (rst_n_i),
      .push_i      (accept && is_write && in_queue),
      .push_data_i (cmd_i.wdata),
      .pop_i       (rd_issue && in_queue),
      .pop_data_o  (queue_rdata),
      .empty_o     (queue_empty)
   );

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) res_valid_q <= 1'b0;
      else if (rd_issue) res_valid_q <= 1'b1;
      else if (res_ready_i) res_valid_q <= 1'b0;
   end

   always_ff @(posedge clk_i) begin
      if (rd_issue) begin
         res_node_q   <= cmd_i.src;
         sel_sram_q   <= in_sram;
         res_status_q <= (in_queue && queue_empty) ? ST_EMPTY : ST_OK;
      end
   end

   always_comb begin
      if (res_valid_q) begin
         res_o.node   = res_node_q;
         res_o.status = res_status_q;
         res_o.rdata  = '0;
         if (res_status_q == ST_OK) res_o.rdata = sel_sram_q ? sram_rdata : queue_rdata;
      end else begin
         res_o.node   = cmd_i.src;         // Unmapped read passes straight through
         res_o.status = ST_UNMAPPED;
         res_o.rdata  = '0;
      end
   end

   assign res_valid_o = res_valid_q || imm_rd;

endmodule

// File: rtl/response_packer.sv
/*
 * Response packer.
 * Turns one read result into a three-flit response packet:
 * header, data high, data low. Flits are held under back-pressure.
 */
module response_packer import dbg_pkg::*; #(
   parameter node_id_t NODE_ID = 5'd1
) (
   input  logic       clk_i,
   input  logic       rst_n_i,
   input  rd_result_t res_i,
   input  logic       res_valid_i,
   output logic       res_ready_o,
   output flit_t      flit_o,
   output logic       flit_valid_o,
   input  logic       flit_ready_i
);

   typedef enum logic [1:0] {IDLE, HDR, DHI, DLO} state_t;

   state_t     state_q;
   rd_result_t res_q;
   flit_data_t hdr_data;

   assign res_ready_o  = state_q == IDLE;
   assign flit_valid_o = state_q != IDLE;

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) state_q <= IDLE;
      else begin
         case (state_q)
            IDLE: if (res_valid_i) state_q <= HDR;
            HDR:  if (flit_ready_i) state_q <= DHI;
            DHI:  if (flit_ready_i) state_q <= DLO;
            DLO:  if (flit_ready_i) state_q <= IDLE;
            default: state_q <= IDLE;
         endcase
      end
   end

   always_ff @(posedge clk_i) begin
      if (res_valid_i && res_ready_o) res_q <= res_i;
   end

   // Back to the requester, from this node
   always_comb begin
      hdr_data = '0;
      hdr_data[HDR_DST_MSB:HDR_DST_LSB] = res_q.node;
      hdr_data[HDR_OP_MSB:HDR_OP_LSB]   = OP_RESP;
      hdr_data[HDR_STS_MSB:HDR_STS_LSB] = res_q.status;
      hdr_data[HDR_SRC_MSB:HDR_SRC_LSB] = NODE_ID;
   end

   always_comb begin
      case (state_q)
         HDR:     flit_o = '{ftype: HEADER, data: hdr_data};
         DHI:     flit_o = '{ftype: PAYLOAD, data: res_q.rdata[31:16]};
         DLO:     flit_o = '{ftype: LAST, data: res_q.rdata[15:0]};
         default: flit_o = '{ftype: PAYLOAD, data: '0};   // Not valid
      endcase
   end

endmodule

// File: rtl/debug_coprocessor.sv
/*
 * Debug co-processor top level.
 * Configuration path only: request decode, bus execution against
 * the SRAM and address queue, and response packing onto the NoC.
 */
module debug_coprocessor import dbg_pkg::*; #(
   parameter node_id_t NODE_ID     = 5'd1,
   parameter int       MEM_AW      = 8,
   parameter int       QUEUE_DEPTH = 8
) (
   input  logic  clk_i,
   input  logic  rst_n_i,
   input  flit_t in_flit_i,
   input  logic  in_valid_i,
   output logic  in_ready_o,
   output flit_t out_flit_o,
   output logic  out_valid_o,
   input  logic  out_ready_i
);

   bus_cmd_t   cmd;
   logic       cmd_valid, cmd_ready;
   rd_result_t res;
   logic       res_valid, res_ready;

   flit_decoder u_flit_decoder (
      .clk_i        (clk_i),
      .rst_n_i      (rst_n_i),
      .flit_i       (in_flit_i),
      .flit_valid_i (in_valid_i),
      .flit_ready_o (in_ready_o),
      .cmd_o        (cmd),
      .cmd_valid_o  (cmd_valid),
      .cmd_ready_i  (cmd_ready)
   );

   bus_executor #(
      .MEM_AW      (MEM_AW),
      .QUEUE_DEPTH (QUEUE_DEPTH)
   ) u_bus_executor (
      .clk_i       (clk_i),
      .rst_n_i     (rst_n_i),
      .cmd_i       (cmd),
      .cmd_valid_i (cmd_valid),
      .cmd_ready_o (cmd_ready),
      .res_o       (res),
      .res_valid_o (res_valid),
      .res_ready_i (res_ready)
   );

   response_packer #(
      .NODE_ID (NODE_ID)
   ) u_response_packer (
      .clk_i        (clk_i),
      .rst_n_i      (rst_n_i),
      .res_i        (res),
      .res_valid_i  (res_valid),
      .res_ready_o  (res_ready),
      .flit_o       (out_flit_o),
      .flit_valid_o (out_valid_o),
      .flit_ready_i (out_ready_i)
   );

endmodule

// File: tb/tb_debug_coprocessor.sv
/*
 * Debug co-processor testbench.
 * Replays request operations from the stimulus file, drives request
 * flits on the falling edge and checks every response packet while
 * the output lane sees random back-pressure.
 */
module tb_debug_coprocessor import dbg_pkg::*; ();

   localparam int       CLK_PERIOD = 20;
   localparam node_id_t TB_NODE    = 5'd3;
   localparam int       SEED       = 32'h1675c7f6;

   typedef struct packed {
      logic [1:0]  op;                     // 1 write, 2 read, 0 stray flit
      node_id_t    src;
      bus_addr_t   addr;
      bus_data_t   wdata;
      rsp_status_t status;                 // Expected read status
      bus_data_t   rdata;
   } stim_t;

   logic       clk, rst_n;
   flit_t      in_flit, out_flit;
   logic       in_valid, in_ready;
   logic       out_valid, out_ready;
   stim_t      stim_q [$];
   rd_result_t exp_q [$];                  // Open reads in request order
   int         n_reads, n_rsp;
   logic       loaded;

   debug_coprocessor #(
      .NODE_ID     (TB_NODE),
      .MEM_AW      (8),
      .QUEUE_DEPTH (4)
   ) u_debug_coprocessor (
      .clk_i       (clk),
      .rst_n_i     (rst_n),
      .in_flit_i   (in_flit),
      .in_valid_i  (in_valid),
      .in_ready_o  (in_ready),
      .out_flit_o  (out_flit),
      .out_valid_o (out_valid),
      .out_ready_i (out_ready)
   );

   always #(CLK_PERIOD / 2) clk = ~clk;

   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   task automatic check(input logic [31:0] got, input logic [31:0] want, input string what);
      if (got !== want) begin
         $display("FAIL at %0t: %s, got %h, expected %h", $time, what, got, want);
         $display("CHECKS FAILED");
         $fatal(1);
      end
   endtask

   // Holds the flit until the decoder takes it on the next rising edge
   task automatic send_flit(input flit_type_t kind, input flit_data_t payload);
      @(negedge clk);
      in_flit  = '{ftype: kind, data: payload};
      in_valid = 1'b1;
      while (!in_ready) @(negedge clk);
   endtask

   task automatic send_request(input stim_t s);
      flit_data_t hdr;
      hdr = '0;
      hdr[HDR_DST_MSB:HDR_DST_LSB] = TB_NODE;
      hdr[HDR_OP_MSB:HDR_OP_LSB]   = s.op;
      hdr[HDR_SRC_MSB:HDR_SRC_LSB] = s.src;
      if (s.op == 2'd0) begin
         send_flit(PAYLOAD, s.wdata[15:0]);                     // Lone flit between packets
      end else if (s.op == OP_WRITE) begin
         send_flit(HEADER, hdr);
         send_flit(PAYLOAD, s.addr[31:16]);
         send_flit(PAYLOAD, s.addr[15:0]);
         send_flit(PAYLOAD, s.wdata[31:16]);
         send_flit(LAST, s.wdata[15:0]);
      end else begin
         exp_q.push_back('{node: s.src, status: s.status, rdata: s.rdata});
         send_flit(HEADER, hdr);
         send_flit(PAYLOAD, s.addr[31:16]);
         send_flit(LAST, s.addr[15:0]);
      end
   endtask

   initial begin : run_stimulus
      int          fd;
      string       line;
      logic [31:0] f_op, f_src, f_addr, f_wdata, f_status, f_rdata;
      clk       = 1'b0;
      rst_n     = 1'b0;
      in_flit   = '0;
      in_valid  = 1'b0;
      out_ready = 1'b0;
      loaded    = 1'b0;
      n_reads   = 0;
      n_rsp     = 0;
      fd = $fopen("tb/dbg_stim.txt", "r");
      if (fd == 0) begin
         $display("Cannot open the stimulus file tb/dbg_stim.txt");
         $display("CHECKS FAILED");
         $fatal(1);
      end
      while (!$feof(fd)) begin
         line = "";
         if ($fgets(line, fd) != 0) begin
            // Comment and blank lines match no fields
            if ($sscanf(line, "%h %h %h %h %h %h", f_op, f_src, f_addr, f_wdata,
                        f_status, f_rdata) == 6) begin
               stim_q.push_back('{op: f_op[1:0], src: f_src[4:0], addr: f_addr,
                                  wdata: f_wdata, status: rsp_status_t'(f_status[1:0]),
                                  rdata: f_rdata});
               if (f_op[1:0] == 2'd2) n_reads++;
            end
         end
      end
      $fclose(fd);
      loaded = 1'b1;
      repeat (10) @(negedge clk);
      rst_n = 1'b1;
      foreach (stim_q[i]) send_request(stim_q[i]);
      @(negedge clk);
      in_valid = 1'b0;
      wait (n_rsp == n_reads);
      repeat (20) @(negedge clk);                               // Room for stray output
      if (out_valid) begin
         $display("Output lane still busy after the last expected response");
         $display("CHECKS FAILED");
         $fatal(1);
      end else begin
         $display("ALL CHECKS PASSED");
         $finish;
      end
   end

   // Each response flit is checked in the half cycle before it transfers
   initial begin : collect_responses
      logic [31:0] rng;
      rd_result_t  want;
      int          idx;
      rng  = SEED;
      idx  = 0;
      want = '0;
      forever begin
         @(negedge clk);
         rng       = xorshift32(rng);
         out_ready = rng[1:0] != 2'b00;                         // Ready about 3 in 4 cycles
         if (rst_n && out_valid && out_ready) begin
            case (idx)
               0: begin
                  check(32'(exp_q.size() != 0), 32'd1, "response with no open read");
                  want = exp_q.pop_front();
                  check(32'(out_flit.ftype), 32'(HEADER), "header flit type");
                  check(32'(out_flit.data[HDR_DST_MSB:HDR_DST_LSB]), 32'(want.node),
                        "header destination");
                  check(32'(out_flit.data[HDR_OP_MSB:HDR_OP_LSB]), 32'(OP_RESP), "header op");
                  check(32'(out_flit.data[HDR_SRC_MSB:HDR_SRC_LSB]), 32'(TB_NODE),
                        "header source");
                  check(32'(out_flit.data[HDR_STS_MSB:HDR_STS_LSB]), 32'(want.status),
                        "response status");
               end
               1: begin
                  check(32'(out_flit.ftype), 32'(PAYLOAD), "data high flit type");
                  check(32'(out_flit.data), 32'(want.rdata[31:16]), "read data high");
               end
               default: begin
                  check(32'(out_flit.ftype), 32'(LAST), "data low flit type");
                  check(32'(out_flit.data), 32'(want.rdata[15:0]), "read data low");
                  n_rsp++;
               end
            endcase
            idx = (idx == 2) ? 0 : idx + 1;
         end
      end
   end

   initial begin : watchdog
      wait (loaded);
      repeat (stim_q.size() * 200 + 10) @(posedge clk);
      $display("Timeout: responses stopped arriving, %0d of %0d received", n_rsp, n_reads);
      $display("CHECKS FAILED");
      $fatal(1);
   end

endmodule

// File: tb/dbg_stim.txt
# op src addr wdata status rdata, all hex; op 1 write, 2 read, 0 stray PAYLOAD flit
# status and rdata are the expected read result: 3 ok, 1 queue empty, 0 unmapped
1 04 00000000 11112222 0 00000000
1 04 00000004 33334444 0 00000000
1 05 000003fc deadbeef 0 00000000
2 07 00000004 00000000 3 33334444
2 04 00000000 00000000 3 11112222
0 00 00000000 0000abcd 0 00000000
2 1f 000003fc 00000000 3 deadbeef
1 04 00000004 55556666 0 00000000
2 02 00000004 00000000 3 55556666
2 02 00000000 00000000 3 11112222
2 09 fe800000 00000000 1 00000000
1 01 fe800000 a0000001 0 00000000
1 01 fe800004 a0000002 0 00000000
0 00 00000000 00001234 0 00000000
1 01 fe8ffffc a0000003 0 00000000
1 01 fe800000 a0000004 0 00000000
1 01 fe800000 a0000005 0 00000000
2 06 fe800000 00000000 3 a0000001
2 06 fe800010 00000000 3 a0000002
2 06 fe800000 00000000 3 a0000003
2 06 fe800000 00000000 3 a0000004
2 06 fe800000 00000000 1 00000000
1 03 80000004 cafef00d 0 00000000
1 03 fe700000 0badf00d 0 00000000
2 03 80000004 00000000 0 00000000
2 0a 00000004 00000000 3 55556666
2 0b fe800000 00000000 1 00000000
0 00 00000000 0000ffff 0 00000000
2 1e 7ffffffc 00000000 3 deadbeef
2 0c fe7ffffc 00000000 0 00000000

// File: dbg_coproc.f
rtl/dbg_pkg.sv
rtl/flit_decoder.sv
rtl/dbg_sram.sv
rtl/address_queue.sv
rtl/bus_executor.sv
rtl/response_packer.sv
rtl/debug_coprocessor.sv
tb/tb_debug_coprocessor.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module tb_debug_coprocessor -f dbg_coproc.f --Mdir obj_dir

if ./obj_dir/Vtb_debug_coprocessor | tee /dev/stderr | grep "ALL CHECKS PASSED" > /dev/null; then
   echo "Simulation passed"
else
   echo "Simulation failed"
   exit 1
fi
